/* verilog/audio_pkg.sv */
//####################
// Audio block shared definitions
// Widths, register map and control bits
//####################
`default_nettype none

package audio_pkg;

    // One channel and one stereo FIFO word, left in the upper half
    localparam int SAMPLE_W = 24;
    localparam int FRAME_W  = 2 * SAMPLE_W;

    // Wishbone register map, byte addresses of 32-bit words
    localparam logic [31:0] REG_CTRL      = 32'h00;
    localparam logic [31:0] REG_STATUS    = 32'h04;
    localparam logic [31:0] REG_THRESHOLD = 32'h08;
    localparam logic [31:0] REG_LEFT      = 32'h0C;
    localparam logic [31:0] REG_RIGHT     = 32'h10;

    // Control register bits
    localparam int CTRL_I2S_EN   = 0;
    localparam int CTRL_DAC_EN   = 1;
    localparam int CTRL_DAC_MODE = 2;
    localparam int CTRL_SW_RST   = 3;

endpackage

`default_nettype wire

/* verilog/clock_generator.sv */
//####################
// Audio clock generator
// Strobes for I2S mclk and sclk toggling
//####################
`timescale 1ns/100ps
`default_nettype none

module clock_generator (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic sw_rst_i,
    output logic mclk_en_o,
    output logic sclk_en_o
);

    logic [3:0] div_cnt;

    // Restart on software reset so framing always starts the same way
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            div_cnt <= '0;
        end else if (sw_rst_i) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 4'd1;
        end
    end

    // Terminal counts, one pulse per 4 and per 16 cycles
    assign mclk_en_o = (div_cnt[1:0] == 2'b11);
    assign sclk_en_o = (div_cnt == 4'hF);

endmodule

`default_nettype wire

/* verilog/sample_fifo.sv */
//####################
// Stereo sample FIFO
// Show-ahead circular buffer with fill level
//####################
`timescale 1ns/100ps
`default_nettype none

module sample_fifo
    import audio_pkg::*;
#(
    parameter int FIFO_LEN_BITS = 4
) (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     clr_i,
    input  logic                     wr_i,
    input  logic [FRAME_W-1:0]       wr_data_i,
    input  logic                     rd_i,
    output logic [FRAME_W-1:0]       rd_data_o,
    output logic                     empty_o,
    output logic                     full_o,
    output logic [FIFO_LEN_BITS:0]   level_o
);

    localparam int DEPTH = 1 << FIFO_LEN_BITS;

    logic [FRAME_W-1:0]       mem [DEPTH];
    logic [FIFO_LEN_BITS-1:0] wr_ptr;
    logic [FIFO_LEN_BITS-1:0] rd_ptr;
    logic                     do_wr;
    logic                     do_rd;

    // Overfill and underflow requests are dropped
    assign do_wr = wr_i && !full_o;
    assign do_rd = rd_i && !empty_o;

    assign empty_o = (level_o == '0);
    assign full_o  = (level_o == (FIFO_LEN_BITS + 1)'(DEPTH));

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            level_o <= '0;
        end else if (clr_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            level_o <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   level_o <= level_o + 1'b1;
                2'b01:   level_o <= level_o - 1'b1;
                default: level_o <= level_o;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    // Head word visible while not empty
    assign rd_data_o = mem[rd_ptr];

endmodule

`default_nettype wire

/* verilog/i2s_master.sv */
//####################
// I2S master transmitter
// One stereo word per 64-bit frame
//####################
`timescale 1ns/100ps
`default_nettype none

module i2s_master
    import audio_pkg::*;
(
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               sw_rst_i,
    input  logic               enable_i,
    input  logic               mclk_en_i,
    input  logic               sclk_en_i,
    input  logic               fifo_valid_i,
    input  logic [FRAME_W-1:0] fifo_data_i,
    output logic               fifo_ready_o,
    output logic               mclk_o,
    output logic               sclk_o,
    output logic               lrclk_o,
    output logic               sdata_o
);

    logic [5:0]          bit_cnt;
    logic [5:0]          bit_nxt;
    logic [SAMPLE_W-1:0] shift_q;
    logic [SAMPLE_W-1:0] right_q;
    logic                sclk_fall;

    // Data and lrclk change on the falling sclk edge
    assign sclk_fall = sclk_en_i && sclk_o;
    assign bit_nxt   = bit_cnt + 6'd1;

    // Pop on the lrclk falling edge, only with a word waiting
    assign fifo_ready_o = sclk_fall && (bit_nxt == 6'd0) && lrclk_o && enable_i
                          && fifo_valid_i && !sw_rst_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mclk_o  <= 1'b0;
            sclk_o  <= 1'b0;
            lrclk_o <= 1'b0;
            sdata_o <= 1'b0;
            bit_cnt <= 6'h3F;
            shift_q <= '0;
            right_q <= '0;
        end else if (sw_rst_i) begin
            mclk_o  <= 1'b0;
            sclk_o  <= 1'b0;
            lrclk_o <= 1'b0;
            sdata_o <= 1'b0;
            bit_cnt <= 6'h3F;
            shift_q <= '0;
            right_q <= '0;
        end else begin
            if (mclk_en_i) begin
                mclk_o <= ~mclk_o;
            end
            if (sclk_en_i) begin
                sclk_o <= ~sclk_o;
            end
            if (sclk_fall) begin
                bit_cnt <= bit_nxt;
                lrclk_o <= bit_nxt[5];
                if (bit_nxt == 6'd0) begin
                    // Left half starts, underrun sends silence
                    sdata_o <= 1'b0;
                    if (fifo_ready_o) begin
                        shift_q <= fifo_data_i[FRAME_W-1 -: SAMPLE_W];
                        right_q <= fifo_data_i[SAMPLE_W-1:0];
                    end else begin
                        shift_q <= '0;
                        right_q <= '0;
                    end
                end else if (bit_nxt == 6'd32) begin
                    // Delay slot before the right channel
                    sdata_o <= 1'b0;
                    shift_q <= right_q;
                end else begin
                    sdata_o <= shift_q[SAMPLE_W-1];
                    shift_q <= {shift_q[SAMPLE_W-2:0], 1'b0};
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/sigma_delta_dac.sv */
//####################
// First-order sigma-delta DAC
//####################
`timescale 1ns/100ps
`default_nettype none

module sigma_delta_dac
    import audio_pkg::*;
#(
    parameter int DAC_DIV = 256
) (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               sw_rst_i,
    input  logic               enable_i,
    input  logic               fifo_valid_i,
    input  logic [FRAME_W-1:0] fifo_data_i,
    output logic               fifo_ready_o,
    output logic               phone_l_o,
    output logic               phone_r_o
);

    localparam int DIV_W = (DAC_DIV > 1) ? $clog2(DAC_DIV) : 1;
    // Offset-binary silence
    localparam logic [SAMPLE_W-1:0] MID = {1'b1, {(SAMPLE_W - 1){1'b0}}};

    logic [DIV_W-1:0]    div_cnt;
    logic                period_end;
    logic [SAMPLE_W-1:0] smp_l;
    logic [SAMPLE_W-1:0] smp_r;
    logic [SAMPLE_W-1:0] acc_l;
    logic [SAMPLE_W-1:0] acc_r;
    logic [SAMPLE_W:0]   sum_l;
    logic [SAMPLE_W:0]   sum_r;

    assign period_end   = (div_cnt == DIV_W'(DAC_DIV - 1));
    assign fifo_ready_o = enable_i && !sw_rst_i && period_end && fifo_valid_i;

    // Carry out of the accumulator is the pulse stream
    assign sum_l = {1'b0, acc_l} + {1'b0, smp_l};
    assign sum_r = {1'b0, acc_r} + {1'b0, smp_r};

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            div_cnt   <= '0;
            smp_l     <= MID;
            smp_r     <= MID;
            acc_l     <= '0;
            acc_r     <= '0;
            phone_l_o <= 1'b0;
            phone_r_o <= 1'b0;
        end else if (sw_rst_i || !enable_i) begin
            div_cnt   <= '0;
            smp_l     <= MID;
            smp_r     <= MID;
            acc_l     <= '0;
            acc_r     <= '0;
            phone_l_o <= 1'b0;
            phone_r_o <= 1'b0;
        end else begin
            div_cnt <= period_end ? '0 : div_cnt + DIV_W'(1);
            // Flip the sign bit to go from two's complement to offset binary
            if (fifo_ready_o) begin
                smp_l <= {~fifo_data_i[FRAME_W-1], fifo_data_i[FRAME_W-2 -: SAMPLE_W-1]};
                smp_r <= {~fifo_data_i[SAMPLE_W-1], fifo_data_i[SAMPLE_W-2:0]};
            end
            acc_l     <= sum_l[SAMPLE_W-1:0];
            acc_r     <= sum_r[SAMPLE_W-1:0];
            phone_l_o <= sum_l[SAMPLE_W];
            phone_r_o <= sum_r[SAMPLE_W];
        end
    end

endmodule

`default_nettype wire

/* verilog/audio_wb_regfile.sv */
//####################
// Audio Wishbone register file
// Control, status, threshold and sample push
//####################
`timescale 1ns/100ps
`default_nettype none

module audio_wb_regfile
    import audio_pkg::*;
#(
    parameter int FIFO_LEN_BITS = 4
) (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic [31:0]            wb_adr_i,
    input  logic [31:0]            wb_dat_i,
    input  logic                   wb_we_i,
    input  logic [3:0]             wb_sel_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_cyc_i,
    input  logic                   fifo_full_i,
    input  logic                   fifo_empty_i,
    input  logic                   fifo_low_i,
    input  logic [FIFO_LEN_BITS:0] fifo_level_i,
    output logic [31:0]            wb_dat_o,
    output logic                   wb_ack_o,
    output logic                   wr_o,
    output logic [FRAME_W-1:0]     wr_data_o,
    output logic [FIFO_LEN_BITS:0] threshold_o,
    output logic                   dac_mode_o,
    output logic                   dac_enable_o,
    output logic                   i2s_enable_o,
    output logic                   sw_rst_o
);

    logic                access;
    logic                wr_en;
    logic                rd_en;
    logic [7:0]          adr;
    logic [SAMPLE_W-1:0] left_q;
    logic                overflow_q;
    logic                push_q;
    logic [31:0]         status_w;
    logic [31:0]         ctrl_w;
    logic [31:0]         rd_mux;

    // No new access during the ack cycle, so ack is one cycle wide
    assign access = wb_stb_i && wb_cyc_i && !wb_ack_o;
    // Any selected lane commits the full word
    assign wr_en  = access && wb_we_i && (|wb_sel_i);
    assign rd_en  = access && !wb_we_i;
    assign adr    = wb_adr_i[7:0];

    always_comb begin
        status_w    = '0;
        status_w[0] = fifo_full_i;
        status_w[1] = fifo_empty_i;
        status_w[2] = fifo_low_i;
        status_w[3] = overflow_q;
        status_w[8 +: FIFO_LEN_BITS + 1] = fifo_level_i;
    end

    // Software reset bit always reads zero
    always_comb begin
        ctrl_w                = '0;
        ctrl_w[CTRL_I2S_EN]   = i2s_enable_o;
        ctrl_w[CTRL_DAC_EN]   = dac_enable_o;
        ctrl_w[CTRL_DAC_MODE] = dac_mode_o;
    end

    always_comb begin
        case (adr)
            REG_CTRL[7:0]:      rd_mux = ctrl_w;
            REG_STATUS[7:0]:    rd_mux = status_w;
            REG_THRESHOLD[7:0]: rd_mux = 32'(threshold_o);
            default:            rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_ack_o     <= 1'b0;
            wb_dat_o     <= '0;
            i2s_enable_o <= 1'b0;
            dac_enable_o <= 1'b0;
            dac_mode_o   <= 1'b0;
            sw_rst_o     <= 1'b0;
            threshold_o  <= '0;
            overflow_q   <= 1'b0;
            push_q       <= 1'b0;
            wr_o         <= 1'b0;
        end else begin
            wb_ack_o <= access;
            wb_dat_o <= rd_en ? rd_mux : '0;
            sw_rst_o <= 1'b0;
            push_q   <= 1'b0;
            // Push lands one cycle after the ack
            wr_o     <= push_q;
            if (wr_en) begin
                case (adr)
                    REG_CTRL[7:0]: begin
                        i2s_enable_o <= wb_dat_i[CTRL_I2S_EN];
                        dac_enable_o <= wb_dat_i[CTRL_DAC_EN];
                        dac_mode_o   <= wb_dat_i[CTRL_DAC_MODE];
                        sw_rst_o     <= wb_dat_i[CTRL_SW_RST];
                    end
                    REG_THRESHOLD[7:0]: threshold_o <= wb_dat_i[FIFO_LEN_BITS:0];
                    REG_RIGHT[7:0]:     push_q      <= 1'b1;
                    default: ;
                endcase
            end
            // Sticky until status is read, a new drop wins
            if (wr_o && fifo_full_i) begin
                overflow_q <= 1'b1;
            end else if (rd_en && (adr == REG_STATUS[7:0])) begin
                overflow_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en && (adr == REG_LEFT[7:0])) begin
            left_q <= wb_dat_i[SAMPLE_W-1:0];
        end
        if (wr_en && (adr == REG_RIGHT[7:0])) begin
            wr_data_o <= {left_q, wb_dat_i[SAMPLE_W-1:0]};
        end
    end

endmodule

`default_nettype wire

/* verilog/psoc_audio.sv */
//####################
// PSoC audio output top level
// Wishbone FIFO feeding I2S or sigma-delta DAC
//####################
`timescale 1ns/100ps
`default_nettype none

module psoc_audio
    import audio_pkg::*;
#(
    parameter int FIFO_LEN_BITS = 4,
    parameter int DAC_DIV       = 256
) (
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic [31:0] wb_adr_i,
    input  logic [31:0] wb_dat_i,
    input  logic        wb_we_i,
    input  logic [3:0]  wb_sel_i,
    input  logic        wb_stb_i,
    input  logic        wb_cyc_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o,
    output logic        fifo_low_o,
    output logic        i2s_mclk_o,
    output logic        i2s_sclk_o,
    output logic        i2s_lrclk_o,
    output logic        i2s_sdata_o,
    output logic        phone_l_o,
    output logic        phone_r_o
);

    logic                   sw_rst;
    logic                   mclk_en;
    logic                   sclk_en;
    logic                   fifo_wr;
    logic [FRAME_W-1:0]     fifo_wr_data;
    logic [FRAME_W-1:0]     fifo_rd_data;
    logic                   fifo_rd;
    logic                   fifo_empty;
    logic                   fifo_full;
    logic                   fifo_valid;
    logic [FIFO_LEN_BITS:0] fifo_level;
    logic [FIFO_LEN_BITS:0] threshold;
    logic                   dac_mode;
    logic                   dac_enable;
    logic                   i2s_enable;
    logic                   i2s_ready;
    logic                   dac_ready;

    assign fifo_valid = !fifo_empty;
    // Only the selected sink may pop
    assign fifo_rd    = dac_mode ? dac_ready : i2s_ready;
    // Interrupt-style flag, level strictly under the threshold
    assign fifo_low_o = (fifo_level < threshold);

    clock_generator u_clk_gen (
        .clk_i, .arst_n_i, .sw_rst_i(sw_rst), .mclk_en_o(mclk_en), .sclk_en_o(sclk_en)
    );

    sample_fifo #(.FIFO_LEN_BITS(FIFO_LEN_BITS)) u_fifo (
        .clk_i, .arst_n_i, .clr_i(sw_rst), .wr_i(fifo_wr), .wr_data_i(fifo_wr_data),
        .rd_i(fifo_rd), .rd_data_o(fifo_rd_data), .empty_o(fifo_empty),
        .full_o(fifo_full), .level_o(fifo_level)
    );

    i2s_master u_i2s (
        .clk_i, .arst_n_i, .sw_rst_i(sw_rst), .enable_i(i2s_enable && !dac_mode),
        .mclk_en_i(mclk_en), .sclk_en_i(sclk_en), .fifo_valid_i(fifo_valid),
        .fifo_data_i(fifo_rd_data), .fifo_ready_o(i2s_ready), .mclk_o(i2s_mclk_o),
        .sclk_o(i2s_sclk_o), .lrclk_o(i2s_lrclk_o), .sdata_o(i2s_sdata_o)
    );

    sigma_delta_dac #(.DAC_DIV(DAC_DIV)) u_dac (
        .clk_i, .arst_n_i, .sw_rst_i(sw_rst), .enable_i(dac_enable && dac_mode),
        .fifo_valid_i(fifo_valid), .fifo_data_i(fifo_rd_data), .fifo_ready_o(dac_ready),
        .phone_l_o, .phone_r_o
    );

    audio_wb_regfile #(.FIFO_LEN_BITS(FIFO_LEN_BITS)) u_regs (
        .clk_i, .arst_n_i, .wb_adr_i, .wb_dat_i, .wb_we_i, .wb_sel_i, .wb_stb_i, .wb_cyc_i,
        .fifo_full_i(fifo_full), .fifo_empty_i(fifo_empty), .fifo_low_i(fifo_low_o),
        .fifo_level_i(fifo_level), .wb_dat_o, .wb_ack_o, .wr_o(fifo_wr),
        .wr_data_o(fifo_wr_data), .threshold_o(threshold), .dac_mode_o(dac_mode),
        .dac_enable_o(dac_enable), .i2s_enable_o(i2s_enable), .sw_rst_o(sw_rst)
    );

endmodule

`default_nettype wire

/* testbench/tb_psoc_audio.sv */
//####################
// Audio block testbench
// Bus tasks, I2S frame decoder and checks
//####################
`timescale 1ns/100ps
`default_nettype none

module tb_psoc_audio
    import audio_pkg::*;
();

    localparam int WB_TIMEOUT  = 16;
    localparam int I2S_TIMEOUT = 30000;

    logic        clk;
    logic        arst_n;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat;
    logic        wb_we;
    logic [3:0]  wb_sel;
    logic        wb_stb;
    logic        wb_cyc;
    logic [31:0] wb_dat_o;
    logic        wb_ack_o;
    logic        fifo_low_o;
    logic        i2s_mclk;
    logic        i2s_sclk;
    logic        i2s_lrclk;
    logic        i2s_sdata;
    logic        phone_l;
    logic        phone_r;

    integer      seed;
    int          errors;
    int          tests_run;
    int          tests_bad;

    // Decoder state
    logic [FRAME_W-1:0]  rx_q [$];
    logic [SAMPLE_W-1:0] rx_shift;
    logic [SAMPLE_W-1:0] rx_left;
    logic                rx_left_ok;
    logic                sclk_prev;
    logic                lr_prev;
    int                  bit_idx;

    psoc_audio u_dut (
        .clk_i(clk), .arst_n_i(arst_n), .wb_adr_i(wb_adr), .wb_dat_i(wb_dat),
        .wb_we_i(wb_we), .wb_sel_i(wb_sel), .wb_stb_i(wb_stb), .wb_cyc_i(wb_cyc),
        .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o), .fifo_low_o(fifo_low_o),
        .i2s_mclk_o(i2s_mclk), .i2s_sclk_o(i2s_sclk), .i2s_lrclk_o(i2s_lrclk),
        .i2s_sdata_o(i2s_sdata), .phone_l_o(phone_l), .phone_r_o(phone_r)
    );

    always #4 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $finish;
    endtask

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        tests_run++;
        if (errors == err_start) begin
            $display("%s: PASS", name);
        end else begin
            tests_bad++;
            $display("%s: FAIL, %0d errors", name, errors - err_start);
        end
    endtask

    // Expected status word from the register layout
    function automatic logic [31:0] status_word(input logic full, input logic empty,
                                                input logic low, input logic ovf,
                                                input int level);
        logic [31:0] w;
        w      = '0;
        w[0]   = full;
        w[1]   = empty;
        w[2]   = low;
        w[3]   = ovf;
        w[15:8] = level[7:0];
        return w;
    endfunction

    // One single-word Wishbone cycle, entered on a falling edge
    task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        int cnt;
        cnt = 0;
        @(negedge clk);
        wb_adr = adr;
        wb_dat = wdata;
        wb_we  = we;
        wb_sel = 4'hF;
        wb_stb = 1'b1;
        wb_cyc = 1'b1;
        @(negedge clk);
        while (!wb_ack_o) begin
            cnt++;
            if (cnt > WB_TIMEOUT) begin
                abort_run("Wishbone cycle never got an ack");
            end
            @(negedge clk);
        end
        rdata  = wb_dat_o;
        wb_stb = 1'b0;
        wb_cyc = 1'b0;
        wb_we  = 1'b0;
        // Sample push lands two cycles after ack
        repeat (2) @(negedge clk);
    endtask

    task automatic wb_write(input logic [31:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [31:0] adr, output logic [31:0] data);
        bus_cycle(1'b0, adr, 32'h0, data);
    endtask

    function automatic int first_nonzero();
        for (int i = 0; i < rx_q.size(); i++) begin
            if (rx_q[i] != '0) begin
                return i;
            end
        end
        return -1;
    endfunction

    // I2S decoder, one bit per rising sclk, counted from each lrclk edge
    always @(negedge clk) begin
        if (i2s_sclk && !sclk_prev) begin
            if (i2s_lrclk != lr_prev) begin
                bit_idx = 0;
            end else if (bit_idx < 63) begin
                bit_idx++;
            end
            lr_prev = i2s_lrclk;
            if (bit_idx >= 1 && bit_idx <= SAMPLE_W) begin
                rx_shift = {rx_shift[SAMPLE_W-2:0], i2s_sdata};
            end else if (bit_idx > SAMPLE_W && bit_idx < 32) begin
                assert (!i2s_sdata) else begin
                    $display("FAILED at %0t ns: i2s_sdata_o = 1, expected 0", $time);
                    errors++;
                end
            end
            if (bit_idx == SAMPLE_W) begin
                if (!i2s_lrclk) begin
                    rx_left    = rx_shift;
                    rx_left_ok = 1'b1;
                end else if (rx_left_ok) begin
                    rx_q.push_back({rx_left, rx_shift});
                    rx_left_ok = 1'b0;
                end
            end
        end
        sclk_prev = i2s_sclk;
    end

    task automatic check_reset_state();
        int          e0;
        int          toggles;
        logic        mclk_prev;
        logic [31:0] rd;
        e0 = errors;
        // Outputs idle low while reset is held
        check_eq("wb_ack_o", wb_ack_o, 1'b0);
        check_eq("fifo_low_o", fifo_low_o, 1'b0);
        check_eq("i2s_mclk_o", i2s_mclk, 1'b0);
        check_eq("i2s_sclk_o", i2s_sclk, 1'b0);
        check_eq("i2s_lrclk_o", i2s_lrclk, 1'b0);
        check_eq("i2s_sdata_o", i2s_sdata, 1'b0);
        check_eq("phone_l_o", phone_l, 1'b0);
        check_eq("phone_r_o", phone_r, 1'b0);
        arst_n = 1'b1;
        wb_read(REG_STATUS, rd);
        check_eq("status", rd, status_word(1'b0, 1'b1, 1'b0, 1'b0, 0));
        wb_read(REG_CTRL, rd);
        check_eq("ctrl", rd, 32'h0);
        check_eq("fifo_low_o", fifo_low_o, 1'b0);
        // mclk toggles once every 4 cycles
        toggles   = 0;
        mclk_prev = i2s_mclk;
        repeat (64) begin
            @(negedge clk);
            if (i2s_mclk !== mclk_prev) begin
                toggles++;
            end
            mclk_prev = i2s_mclk;
        end
        check_eq("i2s_mclk_o toggles", toggles, 16);
        report_test("reset state", e0);
    endtask

    task automatic fill_and_overflow();
        int          e0;
        logic [31:0] rd;
        e0 = errors;
        for (int i = 0; i < 16; i++) begin
            wb_write(REG_LEFT, 32'(i));
            wb_write(REG_RIGHT, 32'(i + 100));
        end
        wb_read(REG_STATUS, rd);
        check_eq("status", rd, status_word(1'b1, 1'b0, 1'b0, 1'b0, 16));
        wb_write(REG_LEFT, 32'h55);
        wb_write(REG_RIGHT, 32'hAA);
        wb_read(REG_STATUS, rd);
        check_eq("status", rd, status_word(1'b1, 1'b0, 1'b0, 1'b1, 16));
        // Overflow is cleared by the read above
        wb_read(REG_STATUS, rd);
        check_eq("status", rd, status_word(1'b1, 1'b0, 1'b0, 1'b0, 16));
        report_test("fill and overflow", e0);
    endtask

    task automatic threshold_and_soft_reset();
        int          e0;
        logic [31:0] rd;
        e0 = errors;
        wb_write(REG_THRESHOLD, 32'd20);
        check_eq("fifo_low_o", fifo_low_o, 1'b1);
        wb_read(REG_THRESHOLD, rd);
        check_eq("threshold", rd, 32'd20);
        wb_write(REG_CTRL, 32'(1 << CTRL_SW_RST));
        wb_read(REG_STATUS, rd);
        check_eq("status", rd, status_word(1'b0, 1'b1, 1'b1, 1'b0, 0));
        wb_read(REG_CTRL, rd);
        check_eq("ctrl", rd, 32'h0);
        report_test("threshold and soft reset", e0);
    endtask

    task automatic play_i2s_samples();
        int                 e0;
        int                 start;
        int                 cnt;
        logic [31:0]        l;
        logic [31:0]        r;
        logic [FRAME_W-1:0] exp_q [4];
        e0 = errors;
        rx_q.delete();
        wb_write(REG_CTRL, 32'(1 << CTRL_I2S_EN));
        for (int i = 0; i < 4; i++) begin
            l = $random(seed);
            r = $random(seed);
            // Only the low 24 bits of each write are kept
            exp_q[i] = {l[SAMPLE_W-1:0], r[SAMPLE_W-1:0]};
            wb_write(REG_LEFT, l);
            wb_write(REG_RIGHT, r);
        end
        start = -1;
        cnt   = 0;
        while (start < 0 || rx_q.size() < start + 6) begin
            @(negedge clk);
            cnt++;
            if (cnt > I2S_TIMEOUT) begin
                abort_run("I2S frames did not arrive before the timeout");
            end
            start = first_nonzero();
        end
        for (int i = 0; i < 4; i++) begin
            check_eq($sformatf("i2s frame %0d", i), rx_q[start + i], exp_q[i]);
        end
        // Underrun frames carry silence
        check_eq("i2s frame 4", rx_q[start + 4], '0);
        check_eq("i2s frame 5", rx_q[start + 5], '0);
        report_test("i2s playback", e0);
    endtask

    task automatic drive_dac_full_scale();
        int          e0;
        int          ones_l;
        int          ones_r;
        logic [31:0] rd;
        e0     = errors;
        ones_l = 0;
        ones_r = 0;
        // Select the DAC with both sinks off while loading
        wb_write(REG_CTRL, 32'(1 << CTRL_DAC_MODE));
        for (int i = 0; i < 8; i++) begin
            wb_write(REG_LEFT, 32'h007F_FFFF);
            wb_write(REG_RIGHT, 32'h0080_0000);
        end
        wb_read(REG_STATUS, rd);
        check_eq("status level", rd[15:8], 8'd8);
        wb_write(REG_CTRL, 32'((1 << CTRL_DAC_MODE) | (1 << CTRL_DAC_EN)));
        repeat (2048) begin
            @(negedge clk);
            ones_l += int'(phone_l);
            ones_r += int'(phone_r);
        end
        assert (ones_l > 1536) else begin
            $display("phone_l_o was high for only %0d of 2048 cycles", ones_l);
            errors++;
        end
        assert (ones_r < 512) else begin
            $display("phone_r_o was high for %0d of 2048 cycles", ones_r);
            errors++;
        end
        wb_read(REG_STATUS, rd);
        check_eq("status level", rd[15:8], 8'd0);
        report_test("dac full scale", e0);
    endtask

    initial begin
        seed       = 32'h02405ae8;
        errors     = 0;
        tests_run  = 0;
        tests_bad  = 0;
        clk        = 1'b0;
        arst_n     = 1'b0;
        wb_adr     = '0;
        wb_dat     = '0;
        wb_we      = 1'b0;
        wb_sel     = 4'h0;
        wb_stb     = 1'b0;
        wb_cyc     = 1'b0;
        rx_shift   = '0;
        rx_left    = '0;
        rx_left_ok = 1'b0;
        sclk_prev  = 1'b0;
        lr_prev    = 1'b0;
        bit_idx    = 63;
        repeat (5) @(posedge clk);
        @(negedge clk);
        check_reset_state();
        fill_and_overflow();
        threshold_and_soft_reset();
        play_i2s_samples();
        drive_dac_full_scale();
        $display("Tests run: %0d, tests with errors: %0d, check errors: %0d",
                 tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
verilog/audio_pkg.sv
verilog/clock_generator.sv
verilog/sample_fifo.sv
verilog/i2s_master.sv
verilog/sigma_delta_dac.sv
verilog/audio_wb_regfile.sv
verilog/psoc_audio.sv
testbench/tb_psoc_audio.sv

/* Makefile */
TOP := tb_psoc_audio

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f filelist.f -o V$(TOP)

# Status comes from grep, so a missing pass line fails the target
run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir
